// ==== Makefile ====
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_exec
FLIST     ?= marocchino_exec.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== exec_alu.sv ====
// one-clock integer ALU, purely combinational; compares need sub_i asserted with setflag_i
`timescale 1ns/10ps
`default_nettype none

module exec_alu
  import marocchino_exec_pkg::*;
(
  input  word_t     op_a_i,
  input  word_t     op_b_i,
  input  alu_opc_t  opc_i,
  input  cmp_opc_t  cmp_i,
  input  wire logic add_i,
  input  wire logic sub_i,
  input  wire logic use_carry_i,
  input  wire logic shift_i,
  input  wire logic logic_i,
  input  wire logic ffl1_i,
  input  wire logic cmov_i,
  input  wire logic movhi_i,
  input  wire logic setflag_i,
  input  wire logic flag_i,
  input  wire logic carry_i,
  output word_t     result_o,
  output logic      flag_set_o,
  output logic      flag_clear_o,
  output logic      carry_set_o,
  output logic      carry_clear_o,
  output logic      ovf_set_o,
  output logic      ovf_clear_o
);

  function automatic word_t bit_rev(input word_t v);
    word_t r;
    for (int i = 0; i < DATA_W; i++) begin
      r[DATA_W-1-i] = v[i];
    end
    return r;
  endfunction

  word_t               b_mux;
  logic                carry_in;
  logic [DATA_W:0]     sum_full;
  word_t               adder_res;
  logic                adder_cout;
  logic                adder_ovf;
  logic                a_eq_b;
  logic                a_lts_b;
  logic                a_ltu_b;
  logic                flag_cond;
  word_t               shift_lsw;
  word_t               shift_msw;
  logic [2*DATA_W-1:0] shift_wide;
  word_t               shift_res;
  logic [3:0]          logic_lut;
  word_t               logic_res;
  word_t               ffl1_res;

  // adder, B inverted for subtract
  assign b_mux      = sub_i ? ~op_b_i : op_b_i;
  assign carry_in   = sub_i | (use_carry_i & carry_i);
  assign sum_full   = {1'b0, op_a_i} + {1'b0, b_mux} + {{DATA_W{1'b0}}, carry_in};
  assign adder_res  = sum_full[DATA_W-1:0];
  assign adder_cout = sum_full[DATA_W];
  // same input signs but result sign flipped
  assign adder_ovf  = (op_a_i[DATA_W-1] == b_mux[DATA_W-1]) &
                      (op_a_i[DATA_W-1] ^ adder_res[DATA_W-1]);

  assign a_eq_b  = (op_a_i == op_b_i);
  assign a_lts_b = adder_res[DATA_W-1] ^ adder_ovf;
  assign a_ltu_b = ~adder_cout;

  always_comb begin
    case (cmp_i)
      CMP_EQ:  flag_cond = a_eq_b;
      CMP_NE:  flag_cond = ~a_eq_b;
      CMP_GTU: flag_cond = ~(a_eq_b | a_ltu_b);
      CMP_GTS: flag_cond = ~(a_eq_b | a_lts_b);
      CMP_GEU: flag_cond = ~a_ltu_b;
      CMP_GES: flag_cond = ~a_lts_b;
      CMP_LTU: flag_cond = a_ltu_b;
      CMP_LTS: flag_cond = a_lts_b;
      CMP_LEU: flag_cond = a_eq_b | a_ltu_b;
      CMP_LES: flag_cond = a_eq_b | a_lts_b;
      default: flag_cond = 1'b0;
    endcase
  end

  // left shift is a right shift between two bit reversals
  assign shift_lsw  = (opc_i == ALU_SLL) ? bit_rev(op_a_i) : op_a_i;
  assign shift_msw  = (opc_i == ALU_SRA) ? {DATA_W{op_a_i[DATA_W-1]}} :
                      (opc_i == ALU_ROR) ? op_a_i : '0;
  assign shift_wide = {shift_msw, shift_lsw} >> op_b_i[SHAMT_W-1:0];
  assign shift_res  = (opc_i == ALU_SLL) ? bit_rev(shift_wide[DATA_W-1:0]) :
                                           shift_wide[DATA_W-1:0];

  // truth table indexed by {a, b}
  always_comb begin
    case (opc_i)
      ALU_AND: logic_lut = 4'b1000;
      ALU_OR:  logic_lut = 4'b1110;
      ALU_XOR: logic_lut = 4'b0110;
      default: logic_lut = 4'b0000;
    endcase
    for (int i = 0; i < DATA_W; i++) begin
      logic_res[i] = logic_lut[{op_a_i[i], op_b_i[i]}];
    end
  end

  // last match in scan order wins
  always_comb begin
    ffl1_res = '0;
    if (opc_i == ALU_FL1) begin
      for (int i = 0; i < DATA_W; i++) begin
        if (op_a_i[i]) ffl1_res = word_t'(i + 1);
      end
    end else begin
      for (int i = DATA_W - 1; i >= 0; i--) begin
        if (op_a_i[i]) ffl1_res = word_t'(i + 1);
      end
    end
  end

  assign result_o = shift_i ? shift_res :
                    ffl1_i  ? ffl1_res  :
                    add_i   ? adder_res :
                    logic_i ? logic_res :
                    cmov_i  ? (flag_i ? op_a_i : op_b_i) :
                    movhi_i ? op_b_i    : '0;

  assign flag_set_o    = setflag_i & flag_cond;
  assign flag_clear_o  = setflag_i & ~flag_cond;
  assign carry_set_o   = add_i & adder_cout;
  assign carry_clear_o = add_i & ~adder_cout;
  assign ovf_set_o     = add_i & adder_ovf;
  assign ovf_clear_o   = add_i & ~adder_ovf;

endmodule

`default_nettype wire

// ==== exec_asserts.sv ====
// writeback latch checks, bound into every exec_wb_latch; payload type follows the latch
`timescale 1ns/10ps
`default_nettype none

module exec_asserts
  import marocchino_exec_pkg::*;
#(
  parameter type payload_t = word_t
) (
  input wire logic clk,
  input wire logic rst,
  input wire logic padv_wb_i,
  input wire logic valid_i,
  input wire logic rdy_i,
  input payload_t  result_i
);

  // ready comes out of reset low
  assert property (@(posedge clk) rst |=> !rdy_i)
    else $error("writeback ready not cleared by reset");

  assert property (@(posedge clk) disable iff (rst) !padv_wb_i |=> $stable(rdy_i))
    else $error("writeback ready changed without writeback advance");

  // payload only loads on valid with advance
  assert property (@(posedge clk) disable iff (rst) !(valid_i && padv_wb_i) |=> $stable(result_i))
    else $error("writeback payload changed without valid and advance");

endmodule

bind exec_wb_latch exec_asserts #(.payload_t(payload_t)) u_asserts (
  .clk(clk), .rst(rst), .padv_wb_i(padv_wb_i), .valid_i(valid_i),
  .rdy_i(rdy_o), .result_i(payload_o)
);

`default_nettype wire

// ==== exec_decode.sv ====
// operand select and unit strobes; all strobes are zero unless issue_i is high
`timescale 1ns/10ps
`default_nettype none

module exec_decode
  import marocchino_exec_pkg::*;
(
  input  wire logic     issue_i,
  input  alu_opc_t      opc_i,
  input  word_t         rfa_i,
  input  word_t         rfb_i,
  input  word_t         imm_i,
  input  wire logic     imm_sel_i,
  output word_t         op_a_o,
  output word_t         op_b_o,
  output logic          add_o,
  output logic          sub_o,
  output logic          use_carry_o,
  output logic          shift_o,
  output logic          logic_o,
  output logic          ffl1_o,
  output logic          cmov_o,
  output logic          movhi_o,
  output logic          setflag_o,
  output logic          one_clk_o,
  output logic          mul_o,
  output logic          div_o,
  output logic          div_signed_o
);

  logic is_mul;
  logic is_div;

  assign op_a_o = rfa_i;
  assign op_b_o = imm_sel_i ? imm_i : rfb_i;

  assign is_mul = (opc_i == ALU_MUL);
  assign is_div = (opc_i == ALU_DIVS) || (opc_i == ALU_DIVU);

  // adder users
  assign add_o       = issue_i & ((opc_i == ALU_ADD) | (opc_i == ALU_ADDC) | (opc_i == ALU_SUB));
  // compares run through the subtractor too
  assign sub_o       = issue_i & ((opc_i == ALU_SUB) | (opc_i == ALU_SETFLAG));
  assign use_carry_o = issue_i & (opc_i == ALU_ADDC);

  assign shift_o   = issue_i & ((opc_i == ALU_SLL) | (opc_i == ALU_SRL) |
                                (opc_i == ALU_SRA) | (opc_i == ALU_ROR));
  assign logic_o   = issue_i & ((opc_i == ALU_AND) | (opc_i == ALU_OR) | (opc_i == ALU_XOR));
  assign ffl1_o    = issue_i & ((opc_i == ALU_FF1) | (opc_i == ALU_FL1));
  assign cmov_o    = issue_i & (opc_i == ALU_CMOV);
  assign movhi_o   = issue_i & (opc_i == ALU_MOVHI);
  assign setflag_o = issue_i & (opc_i == ALU_SETFLAG);

  // multi-cycle units
  assign one_clk_o    = issue_i & ~is_mul & ~is_div;
  assign mul_o        = issue_i & is_mul;
  assign div_o        = issue_i & is_div;
  assign div_signed_o = issue_i & (opc_i == ALU_DIVS);

endmodule

`default_nettype wire

// ==== exec_div.sv ====
// 32-step restoring divider; valid holds until padv_decode_i or the next div_i
`timescale 1ns/10ps
`default_nettype none

module exec_div
  import marocchino_exec_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic flush_i,
  input  wire logic padv_decode_i,
  input  wire logic div_i,
  input  wire logic div_signed_i,
  input  word_t     rfa_i,
  input  word_t     rfb_i,
  output logic      valid_o,
  output div_wb_t   result_o
);

  logic [DIV_CNT_W-1:0] div_cnt;
  logic                 div_valid;
  logic                 div_busy;
  word_t                div_n;
  word_t                div_d;
  word_t                div_r;
  logic                 div_neg;
  logic                 div_dbz;
  logic [DATA_W:0]      div_shl;
  logic [DATA_W:0]      div_diff;
  logic                 div_take;

  // partial remainder shifted left with the next dividend bit
  assign div_shl  = {div_r, div_n[DATA_W-1]};
  assign div_diff = div_shl - {1'b0, div_d};
  assign div_take = (div_shl >= {1'b0, div_d});
  assign div_busy = (div_cnt != '0) && !div_valid;

  // iteration counter; cancel wins over a new load
  always_ff @(posedge clk) begin
    if (rst || padv_decode_i || flush_i) begin
      div_valid <= 1'b0;
      div_cnt   <= '0;
    end else if (div_i) begin
      div_valid <= 1'b0;
      div_cnt   <= DIV_CNT_W'(DATA_W);
    end else if (div_busy) begin
      if (div_cnt == DIV_CNT_W'(1)) begin
        div_valid <= 1'b1;
      end else begin
        div_cnt <= div_cnt - DIV_CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (div_i) begin
      div_r   <= '0;
      div_dbz <= (rfb_i == '0);
      div_neg <= div_signed_i & (rfa_i[DATA_W-1] ^ rfb_i[DATA_W-1]);
      // work on magnitudes, sign restored at the output
      div_n   <= (div_signed_i && rfa_i[DATA_W-1]) ? (~rfa_i + 1'b1) : rfa_i;
      div_d   <= (div_signed_i && rfb_i[DATA_W-1]) ? (~rfb_i + 1'b1) : rfb_i;
    end else if (div_busy) begin
      div_r <= div_take ? div_diff[DATA_W-1:0] : div_shl[DATA_W-1:0];
      div_n <= {div_n[DATA_W-2:0], div_take};
    end
  end

  assign valid_o       = div_valid;
  assign result_o.quot = div_neg ? (~div_n + 1'b1) : div_n;
  assign result_o.dbz  = div_dbz;

endmodule

`default_nettype wire

// ==== exec_mul.sv ====
// 3-stage multiplier, low 32 bits only; a mul_i arriving while the pipe is stalled is dropped
`timescale 1ns/10ps
`default_nettype none

module exec_mul
  import marocchino_exec_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic flush_i,
  input  wire logic padv_wb_i,
  input  wire logic mul_i,
  input  word_t     op_a_i,
  input  word_t     op_b_i,
  output logic      valid_o,
  output word_t     product_o
);

  logic              mul_adv;
  logic [HALF_W-1:0] s1_al;
  logic [HALF_W-1:0] s1_ah;
  logic [HALF_W-1:0] s1_bl;
  logic [HALF_W-1:0] s1_bh;
  logic              s1_rdy;
  word_t             s2_albl;
  word_t             s2_ahbl;
  word_t             s2_bhal;
  logic              s2_rdy;

  // pipe moves unless a finished product waits for writeback
  assign mul_adv = ~s2_rdy | padv_wb_i;

  // stage 1: split operands into halves
  always_ff @(posedge clk) begin
    if (mul_i && mul_adv) begin
      s1_al <= op_a_i[HALF_W-1:0];
      s1_ah <= op_a_i[DATA_W-1:HALF_W];
      s1_bl <= op_b_i[HALF_W-1:0];
      s1_bh <= op_b_i[DATA_W-1:HALF_W];
    end
  end

  // stage 2: partial products, high*high never reaches the low word
  always_ff @(posedge clk) begin
    if (s1_rdy && mul_adv) begin
      s2_albl <= word_t'(s1_al) * word_t'(s1_bl);
      s2_ahbl <= word_t'(s1_ah) * word_t'(s1_bl);
      s2_bhal <= word_t'(s1_bh) * word_t'(s1_al);
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      s1_rdy <= 1'b0;
      s2_rdy <= 1'b0;
    end else if (mul_adv) begin
      s1_rdy <= mul_i;
      s2_rdy <= s1_rdy;
    end
  end

  assign valid_o   = s2_rdy;
  assign product_o = {s2_ahbl[HALF_W-1:0], {HALF_W{1'b0}}} +
                     {s2_bhal[HALF_W-1:0], {HALF_W{1'b0}}} + s2_albl;

endmodule

`default_nettype wire

// ==== exec_top.sv ====
// integer execute stage; flag strobes are combinational and only valid in the issue cycle
`timescale 1ns/10ps
`default_nettype none

module exec_top
  import marocchino_exec_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic issue_i,
  input  alu_opc_t  opc_i,
  input  cmp_opc_t  cmp_i,
  input  word_t     rfa_i,
  input  word_t     rfb_i,
  input  word_t     imm_i,
  input  wire logic imm_sel_i,
  input  wire logic flag_i,
  input  wire logic carry_i,
  input  wire logic padv_wb_i,
  input  wire logic padv_decode_i,
  input  wire logic flush_i,
  output logic      wb_alu_rdy_o,
  output word_t     wb_alu_result_o,
  output logic      wb_mul_rdy_o,
  output word_t     wb_mul_result_o,
  output logic      wb_div_rdy_o,
  output word_t     wb_div_result_o,
  output logic      wb_div_dbz_o,
  output logic      exec_flag_set_o,
  output logic      exec_flag_clear_o,
  output logic      exec_carry_set_o,
  output logic      exec_carry_clear_o,
  output logic      exec_overflow_set_o,
  output logic      exec_overflow_clear_o,
  output logic      exec_valid_o
);

  word_t   op_a, op_b, alu_result, mul_product;
  logic    add, sub, use_carry, shift, logic_op, ffl1, cmov, movhi, setflag;
  logic    one_clk, mul, div, div_signed, mul_valid, div_valid;
  div_wb_t div_result, wb_div;

  exec_decode u_decode (
    .issue_i, .opc_i, .rfa_i, .rfb_i, .imm_i, .imm_sel_i,
    .op_a_o(op_a), .op_b_o(op_b), .add_o(add), .sub_o(sub), .use_carry_o(use_carry),
    .shift_o(shift), .logic_o(logic_op), .ffl1_o(ffl1), .cmov_o(cmov), .movhi_o(movhi),
    .setflag_o(setflag), .one_clk_o(one_clk), .mul_o(mul), .div_o(div),
    .div_signed_o(div_signed)
  );

  exec_alu u_alu (
    .op_a_i(op_a), .op_b_i(op_b), .opc_i, .cmp_i, .add_i(add), .sub_i(sub),
    .use_carry_i(use_carry), .shift_i(shift), .logic_i(logic_op), .ffl1_i(ffl1),
    .cmov_i(cmov), .movhi_i(movhi), .setflag_i(setflag), .flag_i, .carry_i,
    .result_o(alu_result), .flag_set_o(exec_flag_set_o), .flag_clear_o(exec_flag_clear_o),
    .carry_set_o(exec_carry_set_o), .carry_clear_o(exec_carry_clear_o),
    .ovf_set_o(exec_overflow_set_o), .ovf_clear_o(exec_overflow_clear_o)
  );

  exec_mul u_mul (
    .clk, .rst, .flush_i, .padv_wb_i, .mul_i(mul), .op_a_i(op_a), .op_b_i(op_b),
    .valid_o(mul_valid), .product_o(mul_product)
  );

  // divider takes raw register operands, no immediate form
  exec_div u_div (
    .clk, .rst, .flush_i, .padv_decode_i, .div_i(div), .div_signed_i(div_signed),
    .rfa_i, .rfb_i, .valid_o(div_valid), .result_o(div_result)
  );

  exec_wb_latch #(.payload_t(word_t)) u_wb_alu (
    .clk, .rst, .flush_i, .padv_wb_i, .valid_i(one_clk), .payload_i(alu_result),
    .rdy_o(wb_alu_rdy_o), .payload_o(wb_alu_result_o)
  );

  exec_wb_latch #(.payload_t(word_t)) u_wb_mul (
    .clk, .rst, .flush_i, .padv_wb_i, .valid_i(mul_valid), .payload_i(mul_product),
    .rdy_o(wb_mul_rdy_o), .payload_o(wb_mul_result_o)
  );

  exec_wb_latch #(.payload_t(div_wb_t)) u_wb_div (
    .clk, .rst, .flush_i, .padv_wb_i, .valid_i(div_valid), .payload_i(div_result),
    .rdy_o(wb_div_rdy_o), .payload_o(wb_div)
  );

  assign wb_div_result_o = wb_div.quot;
  assign wb_div_dbz_o    = wb_div.dbz;

  assign exec_valid_o = one_clk | mul_valid | div_valid;

endmodule

`default_nettype wire

// ==== exec_wb_latch.sv ====
// writeback result latch; remembers one completion while padv_wb_i is low
`timescale 1ns/10ps
`default_nettype none

module exec_wb_latch
  import marocchino_exec_pkg::*;
#(
  parameter type payload_t = word_t
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic flush_i,
  input  wire logic padv_wb_i,
  input  wire logic valid_i,
  input  payload_t  payload_i,
  output logic      rdy_o,
  output payload_t  payload_o
);

  logic rdy_stored;

  always_ff @(posedge clk) begin
    if (rst) begin
      payload_o <= '0;
    end else if (valid_i && padv_wb_i) begin
      payload_o <= payload_i;
    end
  end

  // flush drops the stored completion only, ready is left as is
  always_ff @(posedge clk) begin
    if (rst) begin
      rdy_o      <= 1'b0;
      rdy_stored <= 1'b0;
    end else if (flush_i) begin
      rdy_stored <= 1'b0;
    end else if (padv_wb_i) begin
      rdy_o      <= valid_i | rdy_stored;
      rdy_stored <= 1'b0;
    end else if (!rdy_stored) begin
      rdy_stored <= valid_i;
    end
  end

endmodule

`default_nettype wire

// ==== marocchino_exec.f ====
marocchino_exec_pkg.sv
exec_decode.sv
exec_alu.sv
exec_mul.sv
exec_div.sv
exec_wb_latch.sv
exec_top.sv
exec_asserts.sv
tb_exec.sv

// ==== marocchino_exec_pkg.sv ====
// shared widths and encodings; 32-bit datapath only, opcode values are local to this core
`default_nettype none

package marocchino_exec_pkg;

  localparam int DATA_W    = 32;
  localparam int HALF_W    = DATA_W / 2;
  localparam int SHAMT_W   = 5;
  localparam int DIV_CNT_W = 6;

  typedef logic [DATA_W-1:0] word_t;

  // execute opcodes
  typedef enum logic [4:0] {
    ALU_NOP     = 5'd0,
    ALU_ADD     = 5'd1,
    ALU_ADDC    = 5'd2,
    ALU_SUB     = 5'd3,
    ALU_AND     = 5'd4,
    ALU_OR      = 5'd5,
    ALU_XOR     = 5'd6,
    ALU_SLL     = 5'd7,
    ALU_SRL     = 5'd8,
    ALU_SRA     = 5'd9,
    ALU_ROR     = 5'd10,
    ALU_FF1     = 5'd11,
    ALU_FL1     = 5'd12,
    ALU_CMOV    = 5'd13,
    ALU_MOVHI   = 5'd14,
    ALU_SETFLAG = 5'd15,
    ALU_MUL     = 5'd16,
    ALU_DIVS    = 5'd17,
    ALU_DIVU    = 5'd18
  } alu_opc_t;

  // set-flag conditions
  typedef enum logic [3:0] {
    CMP_EQ  = 4'd0,
    CMP_NE  = 4'd1,
    CMP_GTU = 4'd2,
    CMP_GTS = 4'd3,
    CMP_GEU = 4'd4,
    CMP_GES = 4'd5,
    CMP_LTU = 4'd6,
    CMP_LTS = 4'd7,
    CMP_LEU = 4'd8,
    CMP_LES = 4'd9
  } cmp_opc_t;

  // divider result with its divide-by-zero marker
  typedef struct packed {
    logic  dbz;
    word_t quot;
  } div_wb_t;

endpackage

`default_nettype wire

// ==== tb_exec.sv ====
// random self-checking testbench; inputs change on falling edges, each divide is cancelled after its result
`timescale 1ns/10ps
`default_nettype none

module tb_exec
  import marocchino_exec_pkg::*;
();

  logic     clk, rst, issue_i, imm_sel_i, flag_i, carry_i;
  logic     padv_wb_i, padv_decode_i, flush_i;
  alu_opc_t opc_i;
  cmp_opc_t cmp_i;
  word_t    rfa_i, rfb_i, imm_i;
  logic     wb_alu_rdy_o, wb_mul_rdy_o, wb_div_rdy_o, wb_div_dbz_o, exec_valid_o;
  word_t    wb_alu_result_o, wb_mul_result_o, wb_div_result_o;
  logic     exec_flag_set_o, exec_flag_clear_o, exec_carry_set_o, exec_carry_clear_o;
  logic     exec_overflow_set_o, exec_overflow_clear_o;
  int       errors, errors_at_start, tests_passed, tests_failed;

  exec_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_mismatch(input string sig, input word_t got, input word_t exp);
    $display("[ERROR] %0t %s got %h expected %h", $time, sig, got, exp);
    errors++;
  endtask

  task automatic abort_run(input string what);
    $display("timeout while waiting for %s", what);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic finish_test(input string name);
    if (errors == errors_at_start) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", name, errors - errors_at_start);
      tests_failed++;
    end
    errors_at_start = errors;
  endtask

  task automatic issue(input alu_opc_t opc, input word_t a, input word_t b, input word_t imm,
                       input logic sel);
    opc_i     = opc;
    rfa_i     = a;
    rfb_i     = b;
    imm_i     = imm;
    imm_sel_i = sel;
    issue_i   = 1'b1;
  endtask

  function automatic logic ready_of(input int unit);
    case (unit)
      0:       return wb_alu_rdy_o;
      1:       return wb_mul_rdy_o;
      default: return wb_div_rdy_o;
    endcase
  endfunction

  // polls one ready output on falling edges, waited counts the edges passed
  task automatic wait_ready(input int unit, input logic level, input int limit,
                            input string what, output int waited);
    waited = 0;
    while (ready_of(unit) !== level && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (ready_of(unit) !== level) abort_run(what);
  endtask

  function automatic word_t model_alu(input alu_opc_t op, input word_t a, input word_t b,
                                      input logic flag, input logic cy);
    word_t r;
    r = '0;
    case (op)
      ALU_ADD:   r = a + b;
      ALU_ADDC:  r = a + b + word_t'(cy);
      ALU_SUB:   r = a - b;
      ALU_AND:   r = a & b;
      ALU_OR:    r = a | b;
      ALU_XOR:   r = a ^ b;
      ALU_SLL:   r = a << b[SHAMT_W-1:0];
      ALU_SRL:   r = a >> b[SHAMT_W-1:0];
      ALU_SRA:   r = $signed(a) >>> b[SHAMT_W-1:0];
      ALU_ROR:   r = (a >> b[SHAMT_W-1:0]) | (a << (DATA_W - int'(b[SHAMT_W-1:0])));
      ALU_CMOV:  r = flag ? a : b;
      ALU_MOVHI: r = b;
      ALU_FF1: begin
        for (int i = 0; i < DATA_W; i++) begin
          if (a[i] && r == '0) r = word_t'(i + 1);
        end
      end
      ALU_FL1: begin
        for (int i = 0; i < DATA_W; i++) begin
          if (a[i]) r = word_t'(i + 1);
        end
      end
      default:   r = '0;
    endcase
    return r;
  endfunction

  function automatic logic model_cmp(input cmp_opc_t c, input word_t a, input word_t b);
    case (c)
      CMP_EQ:  return a == b;
      CMP_NE:  return a != b;
      CMP_GTU: return a > b;
      CMP_GTS: return $signed(a) > $signed(b);
      CMP_GEU: return a >= b;
      CMP_GES: return $signed(a) >= $signed(b);
      CMP_LTU: return a < b;
      CMP_LTS: return $signed(a) < $signed(b);
      CMP_LEU: return a <= b;
      CMP_LES: return $signed(a) <= $signed(b);
      default: return 1'b0;
    endcase
  endfunction

  // subtract reports carry when no borrow occurs
  function automatic logic model_carry(input alu_opc_t op, input word_t a, input word_t b,
                                       input logic cy);
    logic [DATA_W:0] sum;
    if (op == ALU_SUB) return a >= b;
    sum = {1'b0, a} + {1'b0, b};
    if (op == ALU_ADDC && cy) sum = sum + {{DATA_W{1'b0}}, 1'b1};
    return sum[DATA_W];
  endfunction

  // overflow when the exact result does not fit in 32 signed bits
  function automatic logic model_ovf(input alu_opc_t op, input word_t a, input word_t b,
                                     input logic cy);
    longint res;
    if (op == ALU_SUB) begin
      res = longint'($signed(a)) - longint'($signed(b));
    end else begin
      res = longint'($signed(a)) + longint'($signed(b)) + longint'(op == ALU_ADDC && cy);
    end
    return res != longint'($signed(res[DATA_W-1:0]));
  endfunction

  function automatic div_wb_t model_div(input word_t a, input word_t b, input logic sgn);
    word_t mag_a, mag_b, mag_q;
    logic  neg;
    neg   = sgn && (a[DATA_W-1] != b[DATA_W-1]);
    mag_a = (sgn && a[DATA_W-1]) ? -a : a;
    mag_b = (sgn && b[DATA_W-1]) ? -b : b;
    // zero divisor leaves every quotient bit set
    mag_q = (mag_b == '0) ? '1 : mag_a / mag_b;
    return {(b == '0), (neg ? -mag_q : mag_q)};
  endfunction

  initial begin
    word_t    a, b, imm, opb, exp_w;
    logic     sel, exp_bit;
    int       waited;
    div_wb_t  exp_div;
    alu_opc_t op;
    void'($urandom(51));
    rst           = 1'b1;
    issue_i       = 1'b0;
    opc_i         = ALU_NOP;
    cmp_i         = CMP_EQ;
    rfa_i         = '0;
    rfb_i         = '0;
    imm_i         = '0;
    imm_sel_i     = 1'b0;
    flag_i        = 1'b0;
    carry_i       = 1'b0;
    padv_wb_i     = 1'b1;
    padv_decode_i = 1'b0;
    flush_i       = 1'b0;
    errors          = 0;
    errors_at_start = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    // one-clock results, back to back
    for (int i = 0; i < 200; i++) begin
      op      = alu_opc_t'($urandom_range(14, 1));
      a       = $urandom;
      b       = $urandom;
      imm     = $urandom;
      sel     = 1'($urandom);
      flag_i  = 1'($urandom);
      carry_i = 1'($urandom);
      issue(op, a, b, imm, sel);
      exp_w = model_alu(op, a, sel ? imm : b, flag_i, carry_i);
      @(negedge clk);
      issue_i = 1'b0;
      if (wb_alu_rdy_o !== 1'b1) report_mismatch("wb_alu_rdy_o", word_t'(wb_alu_rdy_o), 1);
      if (wb_alu_result_o !== exp_w) report_mismatch("wb_alu_result_o", wb_alu_result_o, exp_w);
    end
    finish_test("one-clock ALU");

    for (int i = 0; i < 100; i++) begin
      cmp_i = cmp_opc_t'($urandom_range(9, 0));
      a     = $urandom;
      b     = $urandom;
      imm   = $urandom;
      sel   = 1'($urandom);
      // equal operands now and then
      if ($urandom_range(3, 0) == 0) begin
        b   = a;
        imm = a;
      end
      issue(ALU_SETFLAG, a, b, imm, sel);
      exp_bit = model_cmp(cmp_i, a, sel ? imm : b);
      #10;
      if (exec_flag_set_o !== exp_bit) begin
        report_mismatch("exec_flag_set_o", word_t'(exec_flag_set_o), word_t'(exp_bit));
      end
      if (exec_flag_clear_o !== !exp_bit) begin
        report_mismatch("exec_flag_clear_o", word_t'(exec_flag_clear_o), word_t'(!exp_bit));
      end
      // an issued set-flag counts as a one-clock operation
      if (exec_valid_o !== 1'b1) report_mismatch("exec_valid_o", word_t'(exec_valid_o), 1);
      @(negedge clk);
      issue_i = 1'b0;
    end
    finish_test("set-flag compares");

    for (int i = 0; i < 100; i++) begin
      op      = alu_opc_t'($urandom_range(3, 1));
      a       = $urandom;
      b       = $urandom;
      imm     = $urandom;
      sel     = 1'($urandom);
      carry_i = 1'($urandom);
      opb     = sel ? imm : b;
      issue(op, a, b, imm, sel);
      #10;
      exp_bit = model_carry(op, a, opb, carry_i);
      if (exec_carry_set_o !== exp_bit) begin
        report_mismatch("exec_carry_set_o", word_t'(exec_carry_set_o), word_t'(exp_bit));
      end
      if (exec_carry_clear_o !== !exp_bit) begin
        report_mismatch("exec_carry_clear_o", word_t'(exec_carry_clear_o), word_t'(!exp_bit));
      end
      exp_bit = model_ovf(op, a, opb, carry_i);
      if (exec_overflow_set_o !== exp_bit) begin
        report_mismatch("exec_overflow_set_o", word_t'(exec_overflow_set_o), word_t'(exp_bit));
      end
      if (exec_overflow_clear_o !== !exp_bit) begin
        report_mismatch("exec_overflow_clear_o", word_t'(exec_overflow_clear_o),
                        word_t'(!exp_bit));
      end
      @(negedge clk);
      issue_i = 1'b0;
    end
    finish_test("carry and overflow");

    for (int i = 0; i < 50; i++) begin
      a   = $urandom;
      b   = $urandom;
      imm = $urandom;
      sel = 1'($urandom);
      issue(ALU_MUL, a, b, imm, sel);
      exp_w = a * (sel ? imm : b);
      @(negedge clk);
      issue_i = 1'b0;
      wait_ready(1, 1'b1, 8, "wb_mul_rdy_o", waited);
      if (waited + 1 != 3) begin
        $display("%0t product ready %0d edges after issue instead of 3", $time, waited + 1);
        errors++;
      end
      if (wb_mul_result_o !== exp_w) report_mismatch("wb_mul_result_o", wb_mul_result_o, exp_w);
    end
    finish_test("multiplier");

    for (int i = 0; i < 40; i++) begin
      a  = $urandom;
      b  = ($urandom_range(4, 0) == 0) ? '0 : ($urandom >> $urandom_range(31, 0));
      if ($urandom_range(1, 0) == 0) begin
        op = ALU_DIVU;
      end else begin
        op = ALU_DIVS;
      end
      issue(op, a, b, $urandom, 1'b0);
      exp_div = model_div(a, b, op == ALU_DIVS);
      @(negedge clk);
      issue_i = 1'b0;
      wait_ready(2, 1'b1, 60, "wb_div_rdy_o", waited);
      if (wb_div_result_o !== exp_div.quot) begin
        report_mismatch("wb_div_result_o", wb_div_result_o, exp_div.quot);
      end
      if (wb_div_dbz_o !== exp_div.dbz) begin
        report_mismatch("wb_div_dbz_o", word_t'(wb_div_dbz_o), word_t'(exp_div.dbz));
      end
      // release the finished divide
      padv_decode_i = 1'b1;
      @(negedge clk);
      padv_decode_i = 1'b0;
      wait_ready(2, 1'b0, 4, "wb_div_rdy_o to drop", waited);
    end
    finish_test("divider");

    // product held while writeback stalls
    a         = $urandom;
    b         = $urandom;
    padv_wb_i = 1'b0;
    issue(ALU_MUL, a, b, '0, 1'b0);
    @(negedge clk);
    issue_i = 1'b0;
    repeat (6) begin
      @(negedge clk);
      if (wb_mul_rdy_o !== 1'b0) report_mismatch("wb_mul_rdy_o", word_t'(wb_mul_rdy_o), 0);
      // stage-2 product waits, so execute stays valid
      if (exec_valid_o !== 1'b1) report_mismatch("exec_valid_o", word_t'(exec_valid_o), 1);
    end
    padv_wb_i = 1'b1;
    wait_ready(1, 1'b1, 4, "held wb_mul_rdy_o", waited);
    exp_w = a * b;
    if (wb_mul_result_o !== exp_w) report_mismatch("wb_mul_result_o", wb_mul_result_o, exp_w);
    wait_ready(1, 1'b0, 4, "wb_mul_rdy_o to drop", waited);

    // same again, flushed before writeback resumes
    padv_wb_i = 1'b0;
    issue(ALU_MUL, $urandom, $urandom, '0, 1'b0);
    @(negedge clk);
    issue_i = 1'b0;
    repeat (6) @(negedge clk);
    flush_i = 1'b1;
    @(negedge clk);
    flush_i   = 1'b0;
    padv_wb_i = 1'b1;
    repeat (6) begin
      @(negedge clk);
      if (wb_mul_rdy_o !== 1'b0) report_mismatch("wb_mul_rdy_o", word_t'(wb_mul_rdy_o), 0);
      if (exec_valid_o !== 1'b0) report_mismatch("exec_valid_o", word_t'(exec_valid_o), 0);
    end
    finish_test("back-pressure and flush");

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
